/* hw/lsu_pkg.sv */
// load/store unit shared definitions
package lsu_pkg;

    // data path and address width
    localparam int xlen = 32;

    // byte lanes per word
    localparam int nbe = xlen / 8;

    // data memory geometry
    localparam int mem_depth = 256;                  // words
    localparam int mem_aw    = $clog2(mem_depth);    // word index bits

    // data window starts right after the instruction area
    localparam logic [xlen-1:0] data_base = 32'd4096;

    // memory operations, bit 3 set for stores
    // low bits follow the funct3 coding of the load/store group
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    // true for the three store codes
    function automatic logic op_is_store(input mem_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

/* hw/store_align.sv */
// store data lane alignment
`timescale 1ns/1ps

module store_align
    import lsu_pkg::*;
(
    input  mem_op_e             op_i,
    input  logic [1:0]          offset_i,   // byte offset within the word
    input  logic [xlen-1:0]     wdata_i,
    output logic [nbe-1:0]      be_o,
    output logic [xlen-1:0]     wdata_o,
    output logic                misalign_o
);

    logic [nbe-1:0] be_raw;

    // alignment rules hold for loads too, lsu_ctrl reuses the flag
    always_comb begin
        case (op_i)
            op_lh, op_lhu, op_sh: misalign_o = offset_i[0];
            op_lw, op_sw:         misalign_o = (offset_i != 2'b00);
            default:              misalign_o = 1'b0;
        endcase
    end

    // replicate the payload so every lane carries it
    always_comb begin
        case (op_i)
            op_sb: begin
                be_raw  = 4'b0001 << offset_i;
                wdata_o = {nbe{wdata_i[7:0]}};
            end
            op_sh: begin
                be_raw  = offset_i[1] ? 4'b1100 : 4'b0011;   // upper or lower half
                wdata_o = {2{wdata_i[15:0]}};
            end
            op_sw: begin
                be_raw  = 4'b1111;
                wdata_o = wdata_i;
            end
            default: begin
                be_raw  = '0;                   // loads write nothing
                wdata_o = wdata_i;
            end
        endcase
    end

    // a refused access never enables a lane
    assign be_o = misalign_o ? '0 : be_raw;

endmodule

/* hw/load_extract.sv */
// load data lane select and extend
`timescale 1ns/1ps

module load_extract
    import lsu_pkg::*;
(
    input  mem_op_e             op_i,
    input  logic [1:0]          offset_i,   // byte offset within the word
    input  logic [xlen-1:0]     word_i,     // raw word from data_mem
    output logic [xlen-1:0]     data_o
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // pick the addressed byte lane
    always_comb begin
        case (offset_i)
            2'b00:   byte_sel = word_i[7:0];
            2'b01:   byte_sel = word_i[15:8];
            2'b10:   byte_sel = word_i[23:16];
            default: byte_sel = word_i[31:24];
        endcase
    end

    // halfwords only at even offsets, bit 0 is ignored here
    assign half_sel = offset_i[1] ? word_i[31:16] : word_i[15:0];

    always_comb begin
        case (op_i)
            op_lb: begin
                data_o = {{(xlen-8){byte_sel[7]}}, byte_sel};     // sign extend
            end
            op_lbu: begin
                data_o = {{(xlen-8){1'b0}}, byte_sel};
            end
            op_lh: begin
                data_o = {{(xlen-16){half_sel[15]}}, half_sel};   // sign extend
            end
            op_lhu: begin
                data_o = {{(xlen-16){1'b0}}, half_sel};
            end
            op_lw: begin
                data_o = word_i;
            end
            default: begin
                data_o = '0;    // stores return nothing
            end
        endcase
    end

endmodule

/* hw/data_mem.sv */
// word organised data memory
`timescale 1ns/1ps

module data_mem
    import lsu_pkg::*;
(
    input  logic                clk_i,
    input  logic                we_i,
    input  logic [nbe-1:0]      be_i,
    input  logic [xlen-1:0]     addr_i,     // byte address
    input  logic [xlen-1:0]     wdata_i,    // already lane aligned
    output logic [xlen-1:0]     rdata_o,
    output logic                in_range_o
);

    logic [xlen-1:0]   mem [mem_depth];
    logic [xlen-1:0]   rel_addr;
    logic [mem_aw-1:0] word_idx;

    // offset into the window, wraps high for addresses below the base
    assign rel_addr = addr_i - data_base;
    assign word_idx = rel_addr[mem_aw+1:2];

    // all bits above the window must be clear
    assign in_range_o = (rel_addr[xlen-1:mem_aw+2] == '0);

    // byte enable write, only inside the window
    always_ff @(posedge clk_i) begin
        if (we_i && in_range_o) begin
            for (int i = 0; i < nbe; i++) begin
                if (be_i[i]) begin
                    mem[word_idx][i*8 +: 8] <= wdata_i[i*8 +: 8];
                end
            end
        end
    end

    // registered read, old word on a write edge
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[word_idx];
    end

endmodule

/* hw/lsu_ctrl.sv */
// load/store handshake controller
`timescale 1ns/1ps

module lsu_ctrl
    import lsu_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,

    // requester side
    input  logic                req_i,
    input  mem_op_e             op_i,
    input  logic [xlen-1:0]     addr_i,
    input  logic [xlen-1:0]     wdata_i,
    output logic                ack_o,
    output logic [xlen-1:0]     rdata_o,
    output logic                err_o,

    // latched request towards the datapath
    output mem_op_e             op_o,
    output logic [xlen-1:0]     addr_o,
    output logic [xlen-1:0]     wdata_o,
    output logic                mem_we_o,

    // datapath status
    input  logic                misalign_i,
    input  logic                in_range_i,
    input  logic [xlen-1:0]     load_data_i
);

    typedef enum logic [1:0] {
        st_idle,
        st_access,
        st_respond,
        st_release
    } state_e;

    state_e state;
    logic   req_err;
    logic   accept;

    assign accept  = (state == st_idle) && req_i;
    assign req_err = misalign_i || !in_range_i;

    // single write strobe during the access cycle
    assign mem_we_o = (state == st_access) && op_is_store(op_o) && !req_err;

    // request payload, held until the next accept
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_o    <= op_i;
            addr_o  <= addr_i;
            wdata_o <= wdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state   <= st_idle;
            ack_o   <= 1'b0;
            err_o   <= 1'b0;
            rdata_o <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (req_i) begin
                        state <= st_access;
                    end
                end
                st_access: begin
                    // memory writes or registers the read word here
                    state <= st_respond;
                end
                st_respond: begin
                    ack_o <= 1'b1;
                    err_o <= req_err;
                    if (req_err || op_is_store(op_o)) begin
                        rdata_o <= '0;
                    end else begin
                        rdata_o <= load_data_i;
                    end
                    state <= st_release;
                end
                st_release: begin
                    // hold the result until the requester lets go
                    if (!req_i) begin
                        ack_o   <= 1'b0;
                        err_o   <= 1'b0;
                        rdata_o <= '0;
                        state   <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* hw/lsu_top.sv */
// load/store unit top level
`timescale 1ns/1ps

module lsu_top
    import lsu_pkg::*;
(
    input  logic                clk_i,
    input  logic                reset_i,
    input  logic                req_i,
    input  mem_op_e             op_i,
    input  logic [xlen-1:0]     addr_i,
    input  logic [xlen-1:0]     wdata_i,
    output logic                ack_o,
    output logic [xlen-1:0]     rdata_o,
    output logic                err_o
);

    mem_op_e         op_q;
    logic [xlen-1:0] addr_q;
    logic [xlen-1:0] wdata_q;
    logic            mem_we;
    logic [nbe-1:0]  mem_be;
    logic [xlen-1:0] mem_wdata;
    logic [xlen-1:0] mem_rdata;
    logic [xlen-1:0] load_data;
    logic            misalign;
    logic            in_range;

    lsu_ctrl lsu_ctrl_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_i       (req_i),
        .op_i        (op_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .err_o       (err_o),
        .op_o        (op_q),
        .addr_o      (addr_q),
        .wdata_o     (wdata_q),
        .mem_we_o    (mem_we),
        .misalign_i  (misalign),
        .in_range_i  (in_range),
        .load_data_i (load_data)
    );

    store_align store_align_inst (
        .op_i       (op_q),
        .offset_i   (addr_q[1:0]),
        .wdata_i    (wdata_q),
        .be_o       (mem_be),
        .wdata_o    (mem_wdata),
        .misalign_o (misalign)
    );

    data_mem data_mem_inst (
        .clk_i      (clk_i),
        .we_i       (mem_we),
        .be_i       (mem_be),
        .addr_i     (addr_q),
        .wdata_i    (mem_wdata),
        .rdata_o    (mem_rdata),
        .in_range_o (in_range)
    );

    load_extract load_extract_inst (
        .op_i     (op_q),
        .offset_i (addr_q[1:0]),
        .word_i   (mem_rdata),
        .data_o   (load_data)
    );

endmodule

/* verification/lsu_asserts.sv */
// load/store controller handshake checks
`timescale 1ns/1ps

module lsu_asserts
    import lsu_pkg::*;
(
    input logic            clk_i,
    input logic            reset_i,
    input logic            req_i,
    input logic            accept_i,    // idle and req sampled high
    input logic            ack_i,
    input logic [xlen-1:0] rdata_i,
    input logic            err_i,
    input logic            mem_we_i,
    input mem_op_e         op_i,        // latched request
    input logic [xlen-1:0] addr_i
);

    int   fail_count = 0;     // failed assertions so far
    logic store_op;
    logic aligned;
    logic in_window;

    assign store_op  = (op_i == op_sb) || (op_i == op_sh) || (op_i == op_sw);
    assign in_window = (addr_i >= data_base) && (addr_i < data_base + 32'(4 * mem_depth));

    // natural alignment of the store width
    always_comb begin
        case (op_i)
            op_sh:   aligned = !addr_i[0];
            op_sw:   aligned = (addr_i[1:0] == 2'b00);
            default: aligned = 1'b1;
        endcase
    end

    // ack registered at the second edge after accept and seen high at the third
    ack_after_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        $rose(ack_i) |-> $past(req_i) && $past(accept_i, 3))
        else begin
            $error("ack_o rose without an accepted request three edges before");
            fail_count++;
        end

    accept_gets_ack: assert property (@(posedge clk_i) disable iff (reset_i)
        $past(accept_i, 3) |-> $rose(ack_i))
        else begin
            $error("accepted request got no ack two cycles later");
            fail_count++;
        end

    ack_held: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i && req_i |=> ack_i)
        else begin
            $error("ack_o dropped while req_i was still high");
            fail_count++;
        end

    // response frozen for the whole ack phase
    result_stable: assert property (@(posedge clk_i) disable iff (reset_i)
        ack_i && $past(ack_i) |-> $stable(rdata_i) && $stable(err_i))
        else begin
            $error("rdata_o or err_o changed while ack_o was high");
            fail_count++;
        end

    no_bad_write: assert property (@(posedge clk_i) disable iff (reset_i)
        mem_we_i |-> store_op && aligned && in_window)
        else begin
            $error("memory write strobe for a refused request");
            fail_count++;
        end

endmodule

bind lsu_ctrl lsu_asserts lsu_asserts_inst (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .accept_i (accept),
    .ack_i    (ack_o),
    .rdata_i  (rdata_o),
    .err_i    (err_o),
    .mem_we_i (mem_we_o),
    .op_i     (op_o),
    .addr_i   (addr_o)
);

/* verification/lsu_tb.sv */
// load/store unit testbench
`timescale 1ns/1ps

module lsu_tb
    import lsu_pkg::*;
();

    logic            clk;
    logic            reset;
    logic            req;
    mem_op_e         op;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            ack;
    logic [xlen-1:0] rdata;
    logic            err;

    logic [7:0]  model_mem [1024];     // byte image of the data window
    logic [31:0] rng_state;
    int          errors;
    int          checks;
    int          tests;
    int          test_errors;
    mem_op_e     op_table [8] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};

    lsu_top lsu_top_inst (
        .clk_i   (clk),
        .reset_i (reset),
        .req_i   (req),
        .op_i    (op),
        .addr_i  (addr),
        .wdata_i (wdata),
        .ack_o   (ack),
        .rdata_o (rdata),
        .err_o   (err)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // access width in bytes
    function automatic int op_size(input mem_op_e o);
        case (o)
            op_lh, op_lhu, op_sh: return 2;
            op_lw, op_sw:         return 4;
            default:              return 1;
        endcase
    endfunction

    // misaligned or outside 4096..5119
    function automatic logic refused(input mem_op_e o, input logic [31:0] a);
        return ((a[1:0] & 2'(op_size(o) - 1)) != 2'b00) || a < 32'd4096 || a > 32'd5119;
    endfunction

    function automatic logic [31:0] predict_load(input mem_op_e o, input logic [31:0] a);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < op_size(o); i++) begin
            v[i*8 +: 8] = model_mem[a[9:0] + 10'(i)];    // little endian
        end
        case (o)
            op_lb:                 return {{24{v[7]}}, v[7:0]};
            op_lh:                 return {{16{v[15]}}, v[15:0]};
            op_lbu, op_lhu, op_lw: return v;
            default:               return '0;
        endcase
    endfunction

    task automatic apply_store(input mem_op_e o, input logic [31:0] a, input logic [31:0] d);
        for (int i = 0; i < op_size(o); i++) begin
            model_mem[a[9:0] + 10'(i)] = d[i*8 +: 8];
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            $display("Fail at %0t ns: %s expected %h got %h", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // one full four-phase transaction, entered 2 ns after an edge
    task automatic run_access(input mem_op_e o, input logic [31:0] a, input logic [31:0] d);
        logic        exp_err;
        logic [31:0] exp_rdata;
        int          waited;
        exp_err   = refused(o, a);
        exp_rdata = exp_err ? 32'd0 : predict_load(o, a);
        if (!exp_err && o inside {op_sb, op_sh, op_sw}) begin
            apply_store(o, a, d);
        end
        op     = o;
        addr   = a;
        wdata  = d;
        req    = 1'b1;
        waited = 0;
        while (!ack && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!ack) begin
            $display("%s at %h got no ack within 20 cycles", o.name(), a);
            errors++;
        end else begin
            check_value("err_o", 32'(exp_err), 32'(err));
            check_value("rdata_o", exp_rdata, rdata);
        end
        req    = 1'b0;
        waited = 0;
        while (ack && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (ack) begin
            $display("ack_o still high 20 cycles after req_i fell");
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors == test_errors) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        mem_op_e     o;
        int          assert_fails;
        reset       = 1'b1;
        req         = 1'b0;
        op          = op_lw;
        addr        = '0;
        wdata       = '0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        test_errors = 0;
        rng_state   = 32'h71971c49;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        repeat (4) begin
            @(posedge clk);
            #2;
            check_value("ack_o", 32'd0, 32'(ack));
            check_value("err_o", 32'd0, 32'(err));
            check_value("rdata_o", 32'd0, rdata);
        end
        report_test("reset");

        // contents are not reset, give every word a known value first
        for (int w = 0; w < mem_depth; w++) begin
            a = data_base + 32'(w * 4);
            run_access(op_sw, a, (a * 32'h9e3779b1) ^ 32'h5ac30f96);
        end
        report_test("fill");

        for (int k = 0; k < 4; k++) begin
            rng_state = xorshift(rng_state);
            run_access(op_sw, 32'd4096 + 32'(k * 340), rng_state);
        end
        for (int k = 0; k < 4; k++) begin
            run_access(op_lw, 32'd4096 + 32'(k * 340), '0);
        end
        report_test("word store and load");

        run_access(op_sw, 32'd4224, 32'h11223344);
        run_access(op_sb, 32'd4225, 32'h556677aa);
        run_access(op_sh, 32'd4226, 32'h99aabeef);
        run_access(op_lw, 32'd4224, '0);
        report_test("partial store merge");

        run_access(op_sb, 32'd4352, 32'h80);
        run_access(op_sb, 32'd4353, 32'h7f);
        run_access(op_sh, 32'd4354, 32'h8001);
        run_access(op_sh, 32'd4356, 32'h1234);
        run_access(op_sh, 32'd4358, 32'h7f80);
        for (int k = 0; k < 8; k++) begin
            a = 32'd4352 + 32'(k);
            run_access(op_lb, a, '0);
            run_access(op_lbu, a, '0);
            if (k % 2 == 0) begin
                run_access(op_lh, a, '0);
                run_access(op_lhu, a, '0);
            end
        end
        report_test("load extension");

        run_access(op_lh, 32'd4161, '0);
        run_access(op_sh, 32'd4163, 32'hffff);
        run_access(op_sw, 32'd4162, 32'hdeadbeef);
        run_access(op_lw, 32'd4161, '0);
        run_access(op_sw, 32'd4092, 32'hdeadbeef);
        run_access(op_sb, 32'd5120, 32'h55);
        run_access(op_lw, 32'd0, '0);
        run_access(op_sw, 32'hfffffffc, 32'h1);
        run_access(op_lw, 32'd4160, '0);
        run_access(op_lw, 32'd4096, '0);
        run_access(op_lw, 32'd5116, '0);
        report_test("refused accesses");

        for (int n = 0; n < 200; n++) begin
            rng_state = xorshift(rng_state);
            r = rng_state;
            o = op_table[r[2:0]];
            a = 32'd4096 + {22'd0, r[12:3]};
            if (r[14:13] != 2'b00) begin
                a = a & ~(32'(op_size(o)) - 32'd1);    // mostly naturally aligned
            end
            if (r[18:15] == 4'd0) begin
                a = r[19] ? a - 32'd1024 : a + 32'd1024;    // just outside the window
            end
            rng_state = xorshift(rng_state);
            run_access(o, a, rng_state);
        end
        report_test("random mix");

        assert_fails = lsu_top_inst.lsu_ctrl_inst.lsu_asserts_inst.fail_count;
        $display("tests %0d, checks %0d, value errors %0d, assertion failures %0d",
                 tests, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sim.f */
hw/lsu_pkg.sv
hw/store_align.sv
hw/load_extract.sv
hw/data_mem.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
verification/lsu_asserts.sv
verification/lsu_tb.sv

/* Makefile */
SIM       := verilator
TOP       := lsu_tb
FILELIST  := sim.f
SIM_FLAGS := --binary --timing --assert -j 0 --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+1000
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "no result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
